// ==== hw/fme_pkg.sv ====
// shared types and per-mode lookups for the FME control unit
// imported by every control module; the mode is held for a whole macroblock

package fme_pkg;

  // macroblock partition type
  typedef enum logic [1:0] {P16X16, P16X8, P8X16, P8X8} mb_type_e;

  // sub-macroblock type, only meaningful for P8X8
  typedef enum logic [1:0] {S8X8, S8X4, S4X8, S4X4} sub_type_e;

  typedef struct packed {
    mb_type_e  mb_type;
    sub_type_e sub_type;
  } fme_mode_t;

  typedef logic [1:0] cnt2_t;

  // loader command
  typedef struct packed {
    logic [4:0] rd_row;
    logic       rd_blk;
    logic       start_rd;
  } rd_cmd_t;

  // position of a pipeline stage inside the macroblock
  typedef struct packed {
    cnt2_t part;
    cnt2_t subpart;
    logic  half;
  } stage_pos_t;

  // reference rows per block, incl. interpolation margin
  localparam logic [4:0] ROWS_16 = 5'd21;
  localparam logic [4:0] ROWS_8  = 5'd13;
  localparam logic [4:0] ROWS_4  = 5'd9;

  function automatic cnt2_t parts_last(fme_mode_t mode);
    case (mode.mb_type)
      P16X16:  return 2'd0;
      P8X8:    return 2'd3;
      default: return 2'd1;
    endcase
  endfunction

  function automatic cnt2_t subparts_last(fme_mode_t mode);
    if (mode.mb_type == P8X8 && (mode.sub_type == S8X4 || mode.sub_type == S4X4)) begin
      return 2'd1;
    end
    return 2'd0;
  endfunction

  // number of 4x4 SATDs per block, minus one
  function automatic logic [2:0] satd_last(fme_mode_t mode);
    case (mode.mb_type)
      P16X16:  return 3'd7;
      P16X8:   return 3'd3;
      P8X16:   return 3'd3;
      default: return (mode.sub_type == S8X8 || mode.sub_type == S4X8) ? 3'd1 : 3'd0;
    endcase
  endfunction

endpackage

// ==== hw/fme_rd_seq.sv ====
// read sequencer of the FME control unit
// walks partitions and sub-partitions, one half-pel and one quarter-pel
// read per sub-partition, and issues the loader commands

module fme_rd_seq (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_fme_i,
  input  fme_pkg::fme_mode_t  mode_i,
  input  logic                end_rd_i,
  input  logic                start_quar_i,
  output logic                idle_o,
  output fme_pkg::rd_cmd_t    rd_o,
  output fme_pkg::stage_pos_t rd_pos_o,
  output logic                end_onemb_o,
  output logic                update_base_o
);
  import fme_pkg::*;

  typedef enum logic [1:0] {IDLE, HALF, QUAR} state_e;

  state_e     state_q;
  state_e     state_d;
  cnt2_t      part_q;
  cnt2_t      sub_q;
  logic       start_rd_q;
  logic       end_onesub;
  logic       end_onepart;
  logic       end_onemb;
  logic [4:0] rows;
  logic       blk;

  // **************************************************************************
  // pass FSM
  // **************************************************************************
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (start_fme_i) state_d = HALF;
      // quarter pass starts once BCS has its half-pel winner
      HALF: if (start_quar_i) state_d = QUAR;
      QUAR: if (end_onesub) state_d = end_onemb ? IDLE : HALF;
      default: state_d = IDLE;
    endcase
  end

  // one quarter read closes a sub-partition
  assign end_onesub  = (state_q == QUAR) & end_rd_i;
  assign end_onepart = end_onesub & (sub_q == subparts_last(mode_i));
  assign end_onemb   = end_onepart & (part_q == parts_last(mode_i));

  // **************************************************************************
  // partition and sub-partition counters
  // **************************************************************************
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      part_q <= '0;
      sub_q  <= '0;
    end else begin
      if (end_onepart) begin
        part_q <= (part_q == parts_last(mode_i)) ? 2'd0 : part_q + 2'd1;
      end
      if (end_onesub) begin
        sub_q <= (sub_q == subparts_last(mode_i)) ? 2'd0 : sub_q + 2'd1;
      end
    end
  end

  // next read on new mb, on quarter start, or after a non-final quarter read
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      start_rd_q <= 1'b0;
    end else begin
      start_rd_q <= start_fme_i | start_quar_i | (end_onesub & ~end_onemb);
    end
  end

  // rows and width of the reference window
  always_comb begin
    blk = (mode_i.mb_type == P16X16) || (mode_i.mb_type == P16X8);
    case (mode_i.mb_type)
      P16X16, P8X16: rows = ROWS_16;
      P16X8:         rows = ROWS_8;
      default:       rows = (mode_i.sub_type == S8X4 || mode_i.sub_type == S4X4) ? ROWS_4
                                                                                 : ROWS_8;
    endcase
  end

  assign rd_o          = '{rd_row: rows, rd_blk: blk, start_rd: start_rd_q};
  assign rd_pos_o      = '{part: part_q, subpart: sub_q, half: state_q == HALF};
  assign idle_o        = (state_q == IDLE);
  assign end_onemb_o   = end_onemb;
  assign update_base_o = end_onesub;

endmodule

// ==== hw/fme_satd_count.sv ====
// counts 4x4 SATD strobes and flags each finished block
// block size follows the macroblock mode

module fme_satd_count (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  fme_pkg::fme_mode_t mode_i,
  input  logic               satd_4x4_valid_i,
  output logic               satd_blk_valid_o
);
  import fme_pkg::*;

  logic [2:0] cnt_q;
  logic       last;

  // last 4x4 of the current block
  assign last = (cnt_q == satd_last(mode_i));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (satd_4x4_valid_i) begin
      cnt_q <= last ? 3'd0 : cnt_q + 3'd1;
    end
  end

  // block done, one cycle after its last 4x4
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      satd_blk_valid_o <= 1'b0;
    end else begin
      satd_blk_valid_o <= satd_4x4_valid_i & last;
    end
  end

endmodule

// ==== hw/fme_stage_track.sv ====
// tracks the block position of the interpolation, SATD and BCS stages
// positions pass down the pipe on each stage's own done event;
// also gives quarter start, the MV address for BCS and end of FME

module fme_stage_track (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_fme_i,
  input  logic                idle_i,
  input  fme_pkg::fme_mode_t  mode_i,
  input  fme_pkg::stage_pos_t rd_pos_i,
  input  logic                end_oneblk_ip_i,
  input  logic                satd_blk_valid_i,
  input  logic                best_candi_i,
  output logic                start_quar_o,
  output fme_pkg::stage_pos_t ip_pos_o,
  output fme_pkg::stage_pos_t satd_pos_o,
  output fme_pkg::stage_pos_t bcs_pos_o,
  output logic                working_mode_satd_o,
  output logic [3:0]          imv_addr_o,
  output logic                end_fme_o
);
  import fme_pkg::*;

  // stage 0 ip, 1 satd, 2 bcs
  stage_pos_t pos_q [3];
  stage_pos_t src [3];
  logic [2:0] evt;
  logic       start_quar;

  assign src[0] = rd_pos_i;
  assign src[1] = pos_q[0];
  assign src[2] = pos_q[1];
  assign evt    = {best_candi_i, satd_blk_valid_i, end_oneblk_ip_i};

  // BCS finished the half-pel decision
  assign start_quar = best_candi_i & pos_q[2].half;

  // **************************************************************************
  // stage position pipe
  // **************************************************************************
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 3; i++) begin
        pos_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (start_fme_i) begin
          // new mb, every stage begins in half pass
          pos_q[i] <= '{part: rd_pos_i.part, subpart: rd_pos_i.subpart, half: 1'b1};
        end else if (start_quar) begin
          pos_q[i].half <= 1'b0;
        end else if (evt[i] && !pos_q[i].half) begin
          pos_q[i] <= src[i];
        end
      end
    end
  end

  // **************************************************************************
  // MV address for the block under selection
  // **************************************************************************
  always_comb begin
    case (mode_i.mb_type)
      P16X16:  imv_addr_o = 4'd0;
      P16X8:   imv_addr_o = {pos_q[2].part[0], 3'b000};
      P8X16:   imv_addr_o = {pos_q[2].part, 2'b00};
      default: begin
        imv_addr_o = {pos_q[2].part, 2'b00};
        // 8x4 and 4x4 step by two per sub-partition
        if (mode_i.sub_type == S8X4 || mode_i.sub_type == S4X4) begin
          imv_addr_o[1] = pos_q[2].subpart[0];
        end
      end
    endcase
  end

  // 4xN blocks run SATD in narrow mode
  assign working_mode_satd_o = !(mode_i.mb_type == P8X8 &&
                                 (mode_i.sub_type == S4X8 || mode_i.sub_type == S4X4));

  // last decision lands after the FSM went idle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      end_fme_o <= 1'b0;
    end else begin
      end_fme_o <= best_candi_i & idle_i;
    end
  end

  assign start_quar_o = start_quar;
  assign ip_pos_o     = pos_q[0];
  assign satd_pos_o   = pos_q[1];
  assign bcs_pos_o    = pos_q[2];

endmodule

// ==== hw/fme_ctrl_top.sv ====
// top level of the FME control unit
// read sequencer and SATD counter side by side, stage tracker on top

module fme_ctrl_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_fme_i,
  input  fme_pkg::fme_mode_t  mode_i,
  input  logic                end_rd_i,
  input  logic                end_oneblk_ip_i,
  input  logic                satd_4x4_valid_i,
  input  logic                best_candi_i,
  output fme_pkg::rd_cmd_t    rd_o,
  output logic                end_onemb_o,
  output logic                update_base_o,
  output logic                satd_blk_valid_o,
  output fme_pkg::stage_pos_t ip_pos_o,
  output fme_pkg::stage_pos_t satd_pos_o,
  output fme_pkg::stage_pos_t bcs_pos_o,
  output logic                working_mode_satd_o,
  output logic [3:0]          imv_addr_o,
  output logic                end_fme_o
);
  import fme_pkg::*;

  stage_pos_t rd_pos;
  logic       start_quar;
  logic       idle;

  fme_rd_seq u_rd_seq (
    .clk_i, .rst_n_i, .start_fme_i, .mode_i, .end_rd_i,
    .start_quar_i (start_quar),
    .idle_o       (idle),
    .rd_o,
    .rd_pos_o     (rd_pos),
    .end_onemb_o, .update_base_o
  );

  fme_satd_count u_satd_count (
    .clk_i, .rst_n_i, .mode_i, .satd_4x4_valid_i, .satd_blk_valid_o
  );

  // block-done strobe also advances the SATD stage
  fme_stage_track u_stage_track (
    .clk_i, .rst_n_i, .start_fme_i,
    .idle_i           (idle),
    .mode_i,
    .rd_pos_i         (rd_pos),
    .end_oneblk_ip_i,
    .satd_blk_valid_i (satd_blk_valid_o),
    .best_candi_i,
    .start_quar_o     (start_quar),
    .ip_pos_o, .satd_pos_o, .bcs_pos_o,
    .working_mode_satd_o, .imv_addr_o, .end_fme_o
  );

endmodule

// ==== dv/fme_tb_props.sv ====
// checker for the FME control unit, bound into the top level
// keeps its own model of reads and block decisions per macroblock;
// each mismatch fails an assertion

module fme_tb_props (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_fme_i,
  input  fme_pkg::fme_mode_t  mode_i,
  input  logic                end_rd_i,
  input  logic                end_oneblk_ip_i,
  input  logic                satd_4x4_valid_i,
  input  logic                best_candi_i,
  input  fme_pkg::rd_cmd_t    rd_i,
  input  logic                end_onemb_i,
  input  logic                update_base_i,
  input  logic                satd_blk_valid_i,
  input  fme_pkg::stage_pos_t ip_pos_i,
  input  fme_pkg::stage_pos_t satd_pos_i,
  input  fme_pkg::stage_pos_t bcs_pos_i,
  input  logic                working_mode_satd_i,
  input  logic [3:0]          imv_addr_i,
  input  logic                end_fme_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import fme_pkg::*;

  int   err_cnt = 0;
  int   rd_cnt;
  int   ip_cnt;
  int   sd_cnt;
  int   bc_cnt;
  int   satd_cnt;
  int   starts;
  logic exp_start_rd;
  logic exp_blk_valid;
  logic exp_end_fme;

  function automatic logic split_sub(fme_mode_t m);
    return m.mb_type == P8X8 && (m.sub_type == S8X4 || m.sub_type == S4X4);
  endfunction

  // block width in pixels
  function automatic int blk_width(fme_mode_t m);
    if (m.mb_type == P16X16 || m.mb_type == P16X8) return 16;
    if (m.mb_type == P8X16) return 8;
    return (m.sub_type == S4X8 || m.sub_type == S4X4) ? 4 : 8;
  endfunction

  // half and quarter read per sub-partition
  function automatic int reads_per_mb(fme_mode_t m);
    int parts;
    parts = (m.mb_type == P16X16) ? 1 : (m.mb_type == P8X8) ? 4 : 2;
    return 2 * parts * (split_sub(m) ? 2 : 1);
  endfunction

  function automatic int satd_per_blk(fme_mode_t m);
    if (m.mb_type == P16X16) return 8;
    if (m.mb_type != P8X8) return 4;
    return (m.sub_type == S8X8 || m.sub_type == S4X8) ? 2 : 1;
  endfunction

  function automatic int rows_for(fme_mode_t m);
    if (m.mb_type == P16X16 || m.mb_type == P8X16) return 21;
    return split_sub(m) ? 9 : 13;
  endfunction

  // position of the n-th block of a mb, half and quarter blocks alternate
  function automatic stage_pos_t pos_for(fme_mode_t m, int blk);
    int         sub_n;
    int         j;
    stage_pos_t p;
    sub_n     = split_sub(m) ? 2 : 1;
    j         = blk / 2;
    p.part    = cnt2_t'(j / sub_n);
    p.subpart = cnt2_t'(j % sub_n);
    p.half    = (blk % 2 == 0);
    return p;
  endfunction

  function automatic int imv_for(fme_mode_t m, stage_pos_t p);
    case (m.mb_type)
      P16X16:  return 0;
      P16X8:   return p.part * 8;
      P8X16:   return p.part * 4;
      default: return p.part * 4 + (split_sub(m) ? p.subpart * 2 : 0);
    endcase
  endfunction

  task automatic check_eq(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $error("Fail at %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
      err_cnt++;
    end
  endtask

  // ************************************************************************
  // per-cycle checks, sampled before the edge
  // ************************************************************************
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_cnt        <= 0;
      ip_cnt        <= 0;
      sd_cnt        <= 0;
      bc_cnt        <= 0;
      satd_cnt      <= 0;
      starts        <= 0;
      exp_start_rd  <= 1'b0;
      exp_blk_valid <= 1'b0;
      exp_end_fme   <= 1'b0;
    end else begin
      check_eq("rd_o.start_rd", rd_i.start_rd, exp_start_rd);
      check_eq("satd_blk_valid_o", satd_blk_valid_i, exp_blk_valid);
      check_eq("end_fme_o", end_fme_i, exp_end_fme);
      // odd read index is a quarter read, last one closes the mb
      check_eq("end_onemb_o", end_onemb_i,
               end_rd_i && rd_cnt == reads_per_mb(mode_i) - 1);
      check_eq("update_base_o", update_base_i, end_rd_i && rd_cnt % 2 == 1);
      check_eq("working_mode_satd_o", working_mode_satd_i, blk_width(mode_i) != 4);
      if (rd_i.start_rd) begin
        check_eq("rd_o.rd_row", rd_i.rd_row, rows_for(mode_i));
        check_eq("rd_o.rd_blk", rd_i.rd_blk, blk_width(mode_i) == 16);
        starts <= starts + 1;
      end
      // each stage shows the block it works on at its own done event
      if (end_oneblk_ip_i) begin
        check_eq("ip_pos_o", ip_pos_i, pos_for(mode_i, ip_cnt));
      end
      if (satd_blk_valid_i) begin
        check_eq("satd_pos_o", satd_pos_i, pos_for(mode_i, sd_cnt));
      end
      if (best_candi_i) begin
        check_eq("bcs_pos_o", bcs_pos_i, pos_for(mode_i, bc_cnt));
        if (bc_cnt % 2 == 1) begin
          check_eq("imv_addr_o", imv_addr_i, imv_for(mode_i, pos_for(mode_i, bc_cnt)));
        end
      end
      if (end_fme_i) begin
        check_eq("read start count", starts, reads_per_mb(mode_i));
      end
      // next read: new mb, half-pel decision, or non-final quarter read
      exp_start_rd  <= start_fme_i | (best_candi_i && bc_cnt % 2 == 0) |
                       (end_rd_i && rd_cnt % 2 == 1 && rd_cnt != reads_per_mb(mode_i) - 1);
      exp_blk_valid <= satd_4x4_valid_i && satd_cnt == satd_per_blk(mode_i) - 1;
      exp_end_fme   <= best_candi_i && bc_cnt == reads_per_mb(mode_i) - 1;
      if (start_fme_i) begin
        rd_cnt <= 0;
        ip_cnt <= 0;
        sd_cnt <= 0;
        bc_cnt <= 0;
        starts <= 0;
      end else begin
        if (end_rd_i) rd_cnt <= rd_cnt + 1;
        if (end_oneblk_ip_i) ip_cnt <= ip_cnt + 1;
        if (satd_blk_valid_i) sd_cnt <= sd_cnt + 1;
        if (best_candi_i) bc_cnt <= bc_cnt + 1;
      end
      if (satd_4x4_valid_i) begin
        satd_cnt <= (satd_cnt == satd_per_blk(mode_i) - 1) ? 0 : satd_cnt + 1;
      end
    end
  end

endmodule

// ==== dv/fme_tb.sv ====
// testbench for the FME control unit
// loader and datapath models answer the DUT; eight macroblocks in random modes

module fme_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fme_pkg::*;

  logic       clk_i;
  logic       rst_n_i;
  logic       start_fme_i;
  fme_mode_t  mode_i;
  logic       end_rd_i;
  logic       end_oneblk_ip_i;
  logic       satd_4x4_valid_i;
  logic       best_candi_i;
  rd_cmd_t    rd_o;
  logic       end_onemb_o;
  logic       update_base_o;
  logic       satd_blk_valid_o;
  stage_pos_t ip_pos_o;
  stage_pos_t satd_pos_o;
  stage_pos_t bcs_pos_o;
  logic       working_mode_satd_o;
  logic [3:0] imv_addr_o;
  logic       end_fme_o;
  integer     seed = 32'heafed6d8;
  int         reads_done = 0;
  int         blocks_done = 0;

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  fme_ctrl_top DUT (.*);

  // checker sits inside the DUT and sees its ports
  bind fme_ctrl_top fme_tb_props u_props (
    .clk_i, .rst_n_i, .start_fme_i, .mode_i, .end_rd_i, .end_oneblk_ip_i,
    .satd_4x4_valid_i, .best_candi_i,
    .rd_i (rd_o), .end_onemb_i (end_onemb_o), .update_base_i (update_base_o),
    .satd_blk_valid_i (satd_blk_valid_o), .ip_pos_i (ip_pos_o), .satd_pos_i (satd_pos_o),
    .bcs_pos_i (bcs_pos_o), .working_mode_satd_i (working_mode_satd_o),
    .imv_addr_i (imv_addr_o), .end_fme_i (end_fme_o)
  );

  always @(DUT.u_props.err_cnt) begin
    if (DUT.u_props.err_cnt != 0) begin
      $display("SIMULATION FAILED");
      $fatal(1, "checker reported a mismatch");
    end
  end

  task automatic timeout_fail(input string what);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout while waiting for %s", what);
  endtask

  function automatic int strobes_per_blk(fme_mode_t m);
    if (m.mb_type == P16X16) return 8;
    if (m.mb_type != P8X8) return 4;
    return (m.sub_type == S8X8 || m.sub_type == S4X8) ? 2 : 1;
  endfunction

  // ************************************************************************
  // loader model, end of read three cycles after each command
  // ************************************************************************
  initial begin
    int n;
    forever begin
      n = 0;
      do begin
        @(posedge clk_i);
        n++;
      end while (!(rst_n_i && rd_o.start_rd) && n < 3000);
      if (n >= 3000) timeout_fail("a read command");
      repeat (3) @(posedge clk_i);
      end_rd_i <= 1'b1;
      @(posedge clk_i);
      end_rd_i <= 1'b0;
      reads_done <= reads_done + 1;
    end
  end

  // ************************************************************************
  // datapath model, one block per finished read
  // ************************************************************************
  initial begin
    int n;
    forever begin
      n = 0;
      do begin
        @(posedge clk_i);
        n++;
      end while (reads_done <= blocks_done && n < 3000);
      if (n >= 3000) timeout_fail("a finished read");
      end_oneblk_ip_i <= 1'b1;
      @(posedge clk_i);
      end_oneblk_ip_i <= 1'b0;
      repeat (strobes_per_blk(mode_i)) begin
        satd_4x4_valid_i <= 1'b1;
        @(posedge clk_i);
      end
      satd_4x4_valid_i <= 1'b0;
      n = 0;
      do begin
        @(posedge clk_i);
        n++;
      end while (!satd_blk_valid_o && n < 20);
      if (n >= 20) timeout_fail("satd_blk_valid_o");
      best_candi_i <= 1'b1;
      @(posedge clk_i);
      best_candi_i <= 1'b0;
      blocks_done++;
    end
  end

  // ************************************************************************
  // reset and macroblock sequence
  // ************************************************************************
  initial begin
    logic [31:0] r;
    int          n;
    rst_n_i          = 1'b0;
    start_fme_i      = 1'b0;
    mode_i           = '0;
    end_rd_i         = 1'b0;
    end_oneblk_ip_i  = 1'b0;
    satd_4x4_valid_i = 1'b0;
    best_candi_i     = 1'b0;
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    for (int mb = 0; mb < 8; mb++) begin
      r = $random(seed);
      mode_i      <= fme_mode_t'(r[3:0]);
      start_fme_i <= 1'b1;
      @(posedge clk_i);
      start_fme_i <= 1'b0;
      n = 0;
      do begin
        @(posedge clk_i);
        n++;
      end while (!end_fme_o && n < 3000);
      if (n >= 3000) timeout_fail("end_fme_o");
      repeat (3) @(posedge clk_i);
    end
    if (DUT.u_props.err_cnt != 0) begin
      $display("SIMULATION FAILED");
      $fatal(1, "checker reported a mismatch");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// ==== compile.f ====
hw/fme_pkg.sv
hw/fme_rd_seq.sv
hw/fme_satd_count.sv
hw/fme_stage_track.sv
hw/fme_ctrl_top.sv
dv/fme_tb_props.sv
dv/fme_tb.sv

// ==== Bender.yml ====
package:
  name: fme_ctrl

sources:
  - files:
      - hw/fme_pkg.sv
      - hw/fme_rd_seq.sv
      - hw/fme_satd_count.sv
      - hw/fme_stage_track.sv
      - hw/fme_ctrl_top.sv
  - target: test
    files:
      - dv/fme_tb_props.sv
      - dv/fme_tb.sv
